/* source/branchPredPkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared widths, counter encoding and the structs that carry resolved
// branches and table writes through the direction predictor
// Every predictor source refers to these by scoped name
////////////////////////////////////////////////////////////////////////////

package branchPredPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and table geometry
  ////////////////////////////////////////////////////////////////////////////

  // Width of a PC on this RV32 core
  localparam int Xlen = 32;

  // Index width into the counter table
  localparam int PredIndexBits = 10;

  // Table depth follows directly from the index width
  localparam int PredEntries = 2 ** PredIndexBits;

  // Width of one saturating counter
  localparam int PredStateBits = 2;

  ////////////////////////////////////////////////////////////////////////////
  // Counter encoding
  ////////////////////////////////////////////////////////////////////////////

  // The upper bit is the predicted direction, so a taken prediction is
  // simply state[1]
  // Counting up moves toward taken, counting down toward not taken
  typedef enum logic [PredStateBits-1:0] {
    strongNotTaken = 2'b00,
    weakNotTaken   = 2'b01,
    weakTaken      = 2'b10,
    strongTaken    = 2'b11
  } predState_t;

  // What an entry reads as before it has ever been written
  localparam predState_t PredResetState = weakNotTaken;

  ////////////////////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////////////////////

  // A branch resolved in execute
  // predState is the counter value that fetch saw when it looked the PC up
  typedef struct packed {
    logic             valid;
    logic [Xlen-1:0]  pc;
    logic             taken;
    predState_t       predState;
  } resolve_t;

  // One write into the counter table
  typedef struct packed {
    logic             en;
    logic [Xlen-1:0]  pc;
    predState_t       state;
  } predUpdate_t;

endpackage

/* source/predictorRam.sv */
////////////////////////////////////////////////////////////////////////////
// Counter table with one synchronous read port and one write port
// Each entry has a valid bit so reset need not clear the whole array
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module predictorRam (
  input  logic                                    clk,
  input  logic                                    rstN,
  // Read data appears one cycle after the index is sampled
  input  logic [branchPredPkg::PredIndexBits-1:0] readIndex,
  output branchPredPkg::predState_t               readData,
  // A write takes effect at the clock edge
  input  logic                                    writeEn,
  input  logic [branchPredPkg::PredIndexBits-1:0] writeIndex,
  input  branchPredPkg::predState_t               writeData
);

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  // Holds one counter state per table entry
  branchPredPkg::predState_t stateMem [branchPredPkg::PredEntries];

  // Marks the entries written since reset
  logic [branchPredPkg::PredEntries-1:0] entryValid;

  // Registered read results
  branchPredPkg::predState_t readStateQ;
  logic                      readValidQ;

  // The array write and the registered read share an edge
  // A read of the index being written returns the old contents
  // The predictor above forwards the new state in that case
  always_ff @(posedge clk) begin
    if (writeEn) begin
      stateMem[writeIndex] <= writeData;
    end
    readStateQ <= stateMem[readIndex];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Valid bits
  ////////////////////////////////////////////////////////////////////////////

  // Reset drops every valid flag at once and a write marks its entry live
  // The registered read flag clears with them
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      entryValid <= '0;
      readValidQ <= 1'b0;
    end else begin
      if (writeEn) begin
        entryValid[writeIndex] <= 1'b1;
      end
      readValidQ <= entryValid[readIndex];
    end
  end

  // An entry never written since reset reads as weakly not taken
  // whatever the array happens to hold
  assign readData = readValidQ ? readStateQ : branchPredPkg::PredResetState;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // An unknown write index would mark an unknown entry valid and corrupt
  // the table without any visible symptom until much later
  writeIndexKnown_a: assert property (
    @(posedge clk) disable iff (!rstN)
    writeEn |-> !$isunknown(writeIndex)
  ) else $error("predictorRam: write with unknown index");

endmodule

/* source/counterUpdate.sv */
////////////////////////////////////////////////////////////////////////////
// Resolve logic for the direction predictor
// Turns a resolved branch into a counter write and a misprediction
// flag, purely combinational
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module counterUpdate (
  // Resolved branch from execute, with the counter seen at lookup
  input  branchPredPkg::resolve_t     resolve,
  // Counter write toward the predictor table
  output branchPredPkg::predUpdate_t  update,
  // High for a valid resolve whose predicted direction was wrong
  output logic                        mispredict
);

  ////////////////////////////////////////////////////////////////////////////
  // Next counter value
  ////////////////////////////////////////////////////////////////////////////

  branchPredPkg::predState_t nextState;

  // Move one step toward the real direction and stick at either end
  always_comb begin
    nextState = resolve.predState;
    if (resolve.taken) begin
      if (resolve.predState != branchPredPkg::strongTaken) begin
        nextState = branchPredPkg::predState_t'(resolve.predState + 2'd1);
      end
    end else begin
      if (resolve.predState != branchPredPkg::strongNotTaken) begin
        nextState = branchPredPkg::predState_t'(resolve.predState - 2'd1);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  // Every valid resolve writes, even when the counter is already
  // saturated, which keeps the entry marked valid in the table
  always_comb begin
    update.en    = resolve.valid;
    update.pc    = resolve.pc;
    update.state = nextState;
  end

  // The upper counter bit was the direction fetch followed
  assign mispredict = resolve.valid && (resolve.predState[1] != resolve.taken);

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // There is no clock here, so the check runs whenever the resolve
  // bus changes
  // Sampled values are those just before the change, so each resolve
  // is checked as it is replaced by the next one
  // An odd PC would mean execute sent something that is not an
  // instruction address at all
  pcAligned_a: assert property (
    @(resolve) resolve.valid |-> !resolve.pc[0]
  ) else $error("counterUpdate: resolve with odd PC %h", $sampled(resolve.pc));

endmodule

/* source/twoBitPredictor.sv */
////////////////////////////////////////////////////////////////////////////
// Two-bit saturating counter direction predictor
// Looks up a counter for the fetch PC every cycle and applies counter
// writes coming back from execute, forwarding same-index writes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module twoBitPredictor (
  input  logic                              clk,
  input  logic                              rstN,
  // Fetch side lookup that is answered one cycle later
  input  logic [branchPredPkg::Xlen-1:0]    lookupPc,
  // Counter write from the resolve logic
  input  branchPredPkg::predUpdate_t        update,
  output branchPredPkg::predState_t         prediction
);

  ////////////////////////////////////////////////////////////////////////////
  // PC hashing
  ////////////////////////////////////////////////////////////////////////////

  // Bit 0 of a RISC-V PC is always zero and bit 1 is only set for
  // compressed code, so the index comes from bits 2 and up
  // Bit 1 is folded into the top index bit so halfword aligned branches
  // spread out instead of landing on their word neighbour
  function automatic logic [branchPredPkg::PredIndexBits-1:0] pcHash(
    input logic [branchPredPkg::Xlen-1:0] pc
  );
    pcHash = {pc[branchPredPkg::PredIndexBits+1] ^ pc[1],
              pc[branchPredPkg::PredIndexBits:2]};
  endfunction

  logic [branchPredPkg::PredIndexBits-1:0] lookupIndex;
  logic [branchPredPkg::PredIndexBits-1:0] updateIndex;

  assign lookupIndex = pcHash(lookupPc);
  assign updateIndex = pcHash(update.pc);

  ////////////////////////////////////////////////////////////////////////////
  // Table
  ////////////////////////////////////////////////////////////////////////////

  branchPredPkg::predState_t tableData;

  predictorRam ram_i (
    .clk        (clk),
    .rstN       (rstN),
    .readIndex  (lookupIndex),
    .readData   (tableData),
    .writeEn    (update.en),
    .writeIndex (updateIndex),
    .writeData  (update.state)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Same-index forwarding
  ////////////////////////////////////////////////////////////////////////////

  // The table returns old data when it is read and written at one index
  // on the same edge, so the new counter is kept alongside a flag
  logic                      forwardHit;
  logic                      forwardQ;
  branchPredPkg::predState_t forwardStateQ;

  // Only a real write may forward since an idle update bus can carry any PC
  assign forwardHit = update.en && (updateIndex == lookupIndex);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      forwardQ <= 1'b0;
    end else begin
      forwardQ <= forwardHit;
    end
  end

  // Captures the update state every cycle for the forward path
  always_ff @(posedge clk) begin
    forwardStateQ <= update.state;
  end

  assign prediction = forwardQ ? forwardStateQ : tableData;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Covers the forward registers and the table read path together,
  // including entries that were never written since reset
  predictionKnown_a: assert property (
    @(posedge clk) disable iff (!rstN)
    !$isunknown(prediction)
  ) else $error("twoBitPredictor: prediction is unknown");

endmodule

/* source/branchPredictor.sv */
////////////////////////////////////////////////////////////////////////////
// Top level of the fetch direction predictor
// Fetch drives a lookup PC every cycle, execute drives resolved branches
// and receives the misprediction flag
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module branchPredictor (
  input  logic                            clk,
  input  logic                            rstN,
  // Fetch PC, prediction follows one cycle later
  input  logic [branchPredPkg::Xlen-1:0]  lookupPc,
  // Resolved branch, consumed in any cycle where valid is high
  input  branchPredPkg::resolve_t         resolve,
  // Counter state for the PC sampled at the previous edge
  output branchPredPkg::predState_t       prediction,
  // Same cycle as the resolve that caused it
  output logic                            mispredict
);

  ////////////////////////////////////////////////////////////////////////////
  // Resolve path
  ////////////////////////////////////////////////////////////////////////////

  // Counter write from the resolve logic into the table
  branchPredPkg::predUpdate_t update;

  // Computes the saturated counter and flags wrong directions
  counterUpdate counterUpdate_i (
    .resolve    (resolve),
    .update     (update),
    .mispredict (mispredict)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Lookup path
  ////////////////////////////////////////////////////////////////////////////

  // Holds the counter table and returns a state per lookup
  // A write at edge N is visible to a same-index lookup sampled at that
  // same edge through forwarding, and to any later lookup through the table
  twoBitPredictor twoBitPredictor_i (
    .clk        (clk),
    .rstN       (rstN),
    .lookupPc   (lookupPc),
    .update     (update),
    .prediction (prediction)
  );

endmodule

/* dv/branchPredictorTb.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the fetch direction predictor
// Drives lookups and resolves on the falling edge, keeps a reference table
// and compares prediction and mispredict at every rising edge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module branchPredictorTb;

  localparam int EdgeTimeoutNs = 100;
  localparam int RandomCycles = 2000;
  localparam int unsigned Seed = 32'hc118_2c50;

  logic                           clk = 1'b0;
  logic                           rstN;
  logic [branchPredPkg::Xlen-1:0] lookupPc;
  branchPredPkg::resolve_t        resolve;
  branchPredPkg::predState_t      prediction;
  logic                           mispredict;

  branchPredictor dut_i (
    .clk        (clk),
    .rstN       (rstN),
    .lookupPc   (lookupPc),
    .resolve    (resolve),
    .prediction (prediction),
    .mispredict (mispredict)
  );

  // 20 ns period
  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  branchPredPkg::predState_t modelState [branchPredPkg::PredEntries];
  bit                        modelValid [branchPredPkg::PredEntries];
  branchPredPkg::predState_t expPrediction;
  bit                        checkOn = 1'b0;
  bit                        stalled = 1'b0;
  int                        errorCount = 0;
  int                        checkCount = 0;
  int                        testCount = 0;

  // The index is PC bits 11 down to 2, and a set PC bit 1 flips its top bit
  function automatic logic [branchPredPkg::PredIndexBits-1:0] pcIndex(
    input logic [branchPredPkg::Xlen-1:0] pc
  );
    logic [branchPredPkg::PredIndexBits-1:0] idx;
    idx = pc[branchPredPkg::PredIndexBits+1:2];
    if (pc[1])
      idx[branchPredPkg::PredIndexBits-1] = ~idx[branchPredPkg::PredIndexBits-1];
    return idx;
  endfunction

  // Entries never written since reset read as weakly not taken
  function automatic branchPredPkg::predState_t modelRead(
    input logic [branchPredPkg::PredIndexBits-1:0] idx
  );
    return modelValid[idx] ? modelState[idx] : branchPredPkg::PredResetState;
  endfunction

  // One saturating step toward the real direction
  function automatic branchPredPkg::predState_t nextCounter(
    input branchPredPkg::predState_t state,
    input logic                      taken
  );
    branchPredPkg::predState_t next;
    case (state)
      branchPredPkg::strongNotTaken:
        next = taken ? branchPredPkg::weakNotTaken : branchPredPkg::strongNotTaken;
      branchPredPkg::weakNotTaken:
        next = taken ? branchPredPkg::weakTaken : branchPredPkg::strongNotTaken;
      branchPredPkg::weakTaken:
        next = taken ? branchPredPkg::strongTaken : branchPredPkg::weakNotTaken;
      default:
        next = taken ? branchPredPkg::strongTaken : branchPredPkg::weakTaken;
    endcase
    return next;
  endfunction

  // Fetch followed taken for both taken states
  function automatic logic wrongDirection(
    input branchPredPkg::predState_t state,
    input logic                      taken
  );
    logic predictedTaken;
    predictedTaken = (state == branchPredPkg::weakTaken) ||
                     (state == branchPredPkg::strongTaken);
    return predictedTaken != taken;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Comparison at every rising edge
  ////////////////////////////////////////////////////////////////////////////

  // Inputs change only on the falling edge, so here they are stable and the
  // DUT registers still hold the values from the previous edge
  always @(posedge clk) begin : compare
    logic [branchPredPkg::PredIndexBits-1:0] resIdx;
    logic                                    expMis;
    if (checkOn) begin
      checkCount += 2;
      if (prediction !== expPrediction) begin
        errorCount++;
        $display("mismatch prediction: expected %h, actual %h", expPrediction, prediction);
      end
      expMis = resolve.valid && wrongDirection(resolve.predState, resolve.taken);
      if (mispredict !== expMis) begin
        errorCount++;
        $display("mismatch mispredict: expected %h, actual %h", expMis, mispredict);
      end
      // Write first so a same-index lookup at this edge sees the new state
      if (resolve.valid) begin
        resIdx = pcIndex(resolve.pc);
        modelState[resIdx] = nextCounter(resolve.predState, resolve.taken);
        modelValid[resIdx] = 1'b1;
      end
      expPrediction = modelRead(pcIndex(lookupPc));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // Each edge wait gives up after EdgeTimeoutNs
  task automatic stepFalling(input int cycles);
    int done;
    done = 0;
    while (done < cycles && !stalled) begin
      fork
        @(negedge clk);
        begin
          #(EdgeTimeoutNs);
          stalled = 1'b1;
        end
      join_any
      disable fork;
      done++;
    end
    if (stalled) begin
      $display("timeout: no falling clock edge within %0d ns", EdgeTimeoutNs);
      $display("=== FAIL ===");
      $finish;
    end
  endtask

  // Drives one cycle of lookup and resolve and steps to the next falling edge
  // The resolve carries the model's current state as the pipeline would
  task automatic driveCycle(
    input logic [branchPredPkg::Xlen-1:0] pc,
    input logic                           resValid,
    input logic [branchPredPkg::Xlen-1:0] resPc,
    input logic                           resTaken
  );
    branchPredPkg::resolve_t res;
    res.valid = resValid;
    res.pc = resPc;
    res.taken = resTaken;
    res.predState = modelRead(pcIndex(resPc));
    lookupPc = pc;
    resolve = res;
    stepFalling(1);
  endtask

  // Literal check of the state returned for the last driven lookup
  task automatic expectPrediction(input branchPredPkg::predState_t want);
    checkCount++;
    if (prediction !== want) begin
      errorCount++;
      $display("mismatch prediction: expected %h, actual %h", want, prediction);
    end
  endtask

  task automatic finishTest(input string name, input int errorsBefore);
    testCount++;
    if (errorCount == errorsBefore)
      $display("test %s: passed", name);
    else
      $display("test %s: failed with %0d errors", name, errorCount - errorsBefore);
  endtask

  // Small PC window so random lookups and resolves collide often
  function automatic logic [branchPredPkg::Xlen-1:0] randomPc();
    logic [branchPredPkg::Xlen-1:0] pc;
    pc = 32'h0000_1000 + (($urandom % 16) << 1);
    if ($urandom % 4 == 0)
      pc = pc | 32'h0010_0000;
    return pc;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    int unsigned                   seedVar;
    int                            errorsBefore;
    logic [branchPredPkg::Xlen-1:0] pcA;
    logic [branchPredPkg::Xlen-1:0] pcB;
    branchPredPkg::predState_t     upSteps [3];
    branchPredPkg::predState_t     downSteps [4];
    logic                          mixTaken [8];
    seedVar = Seed;
    void'($urandom(seedVar));
    rstN = 1'b0;
    lookupPc = '0;
    resolve = '0;
    for (int i = 0; i < branchPredPkg::PredEntries; i++) begin
      modelValid[i] = 1'b0;
      modelState[i] = branchPredPkg::PredResetState;
    end
    stepFalling(5);
    rstN = 1'b1;
    expPrediction = branchPredPkg::PredResetState;
    checkOn = 1'b1;

    // Nothing written yet, so every index reads weakly not taken
    errorsBefore = errorCount;
    for (int i = 0; i < 50; i++) begin
      driveCycle($urandom & 32'hffff_fffe, 1'b0, '0, 1'b0);
      expectPrediction(branchPredPkg::weakNotTaken);
    end
    finishTest("reset state", errorsBefore);

    // Each write is checked once forwarded and once through the table
    errorsBefore = errorCount;
    pcA = 32'h0000_0100;
    upSteps = '{branchPredPkg::weakTaken, branchPredPkg::strongTaken,
                branchPredPkg::strongTaken};
    downSteps = '{branchPredPkg::weakTaken, branchPredPkg::weakNotTaken,
                  branchPredPkg::strongNotTaken, branchPredPkg::strongNotTaken};
    foreach (upSteps[i]) begin
      driveCycle(pcA, 1'b1, pcA, 1'b1);
      expectPrediction(upSteps[i]);
      driveCycle(pcA, 1'b0, pcA, 1'b0);
      expectPrediction(upSteps[i]);
    end
    foreach (downSteps[i]) begin
      driveCycle(pcA, 1'b1, pcA, 1'b0);
      expectPrediction(downSteps[i]);
      driveCycle(pcA, 1'b0, pcA, 1'b0);
      expectPrediction(downSteps[i]);
    end
    finishTest("saturation", errorsBefore);

    errorsBefore = errorCount;
    pcA = 32'h0000_0200;
    pcB = 32'h0000_0300;
    driveCycle(pcA, 1'b1, pcA, 1'b1);
    expectPrediction(branchPredPkg::weakTaken);
    // A write elsewhere must not leak into the pcB lookup
    driveCycle(pcB, 1'b1, pcA, 1'b1);
    expectPrediction(branchPredPkg::weakNotTaken);
    driveCycle(pcA, 1'b0, pcA, 1'b0);
    expectPrediction(branchPredPkg::strongTaken);
    // An idle resolve bus at the same index must not forward
    driveCycle(pcA, 1'b0, pcA, 1'b0);
    expectPrediction(branchPredPkg::strongTaken);
    finishTest("forwarding", errorsBefore);

    // Bit 20 lies above the index and bits 1 and 11 cancel in the hash
    errorsBefore = errorCount;
    pcA = 32'h0000_0448;
    driveCycle(pcA, 1'b1, pcA, 1'b1);
    driveCycle(pcA | 32'h0010_0000, 1'b0, pcA, 1'b0);
    expectPrediction(branchPredPkg::weakTaken);
    driveCycle(pcA, 1'b1, pcA ^ 32'h0000_0802, 1'b1);
    driveCycle(pcA, 1'b0, pcA, 1'b0);
    expectPrediction(branchPredPkg::strongTaken);
    driveCycle(pcA ^ 32'h0000_0802, 1'b0, pcA, 1'b0);
    expectPrediction(branchPredPkg::strongTaken);
    finishTest("hash aliasing", errorsBefore);

    // Visits every state with both directions and idles between resolves
    errorsBefore = errorCount;
    pcA = 32'h0000_0600;
    mixTaken = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    foreach (mixTaken[i]) begin
      driveCycle(pcB, 1'b1, pcA, mixTaken[i]);
      driveCycle(pcB, 1'b0, pcA, mixTaken[i]);
    end
    finishTest("mispredict", errorsBefore);

    errorsBefore = errorCount;
    for (int i = 0; i < RandomCycles; i++) begin
      pcA = randomPc();
      pcB = randomPc();
      driveCycle(pcA, ($urandom % 2) == 1, pcB, ($urandom % 2) == 1);
    end
    driveCycle(pcA, 1'b0, pcB, 1'b0);
    finishTest("random mix", errorsBefore);

    $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    if (errorCount == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

/* sim.f */
source/branchPredPkg.sv
source/predictorRam.sv
source/counterUpdate.sv
source/twoBitPredictor.sv
source/branchPredictor.sv
dv/branchPredictorTb.sv

/* Bender.yml */
package:
  name: branch_predictor

sources:
  - source/branchPredPkg.sv
  - source/predictorRam.sv
  - source/counterUpdate.sv
  - source/twoBitPredictor.sv
  - source/branchPredictor.sv
  - target: test
    files:
      - dv/branchPredictorTb.sv
